//--- coh_dir_chk.sv
/*
  lookup unit checker
  result pulse width, result only while busy and a clean
  transfer LCE when no transfer is flagged
*/
`timescale 1ns/1ns
`default_nettype none

module coh_dir_chk (
  input logic                     clk_i,
  input logic                     reset_i,
  input logic                     busy_i,
  input logic                     result_v_i,
  input coh_req_pkg::gad_result_s result_i
);

  // failed assertion count, read by the testbench at the end
  int fail_cnt = 0;

  // result valid lasts exactly one cycle
  a_result_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    result_v_i |=> !result_v_i)
    else begin
      $error("result_v_o held high for more than one cycle");
      fail_cnt++;
    end

  a_result_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    result_v_i |-> busy_i)
    else begin
      $error("result_v_o raised while busy_o is low");
      fail_cnt++;
    end

  // no transfer means no transfer target
  a_xfer_lce: assert property (@(posedge clk_i) disable iff (reset_i)
    !result_i.transfer_flag |-> (result_i.transfer_lce == '0))
    else begin
      $error("transfer_lce nonzero without transfer_flag");
      fail_cnt++;
    end

endmodule

bind coh_dir_top coh_dir_chk u_chk (
  .clk_i(clk_i), .reset_i(reset_i), .busy_i(busy_o),
  .result_v_i(result_v_o), .result_i(result_o)
);

`default_nettype wire

//--- coh_dir_pkg.sv
/*
  coherence directory package
  sizes of the directory, MESI state encoding and the layout
  of one directory entry and of one LCE row
*/
`default_nettype none

package coh_dir_pkg;

  // directory geometry
  localparam int num_lce_c   = 4;
  localparam int lce_assoc_c = 2;
  localparam int tag_width_c = 8;

  // index widths
  localparam int lce_id_w_c = $clog2(num_lce_c);
  localparam int way_w_c    = $clog2(lce_assoc_c);

  // MESI encoding
  typedef enum logic [1:0] {
    coh_i = 2'd0,
    coh_s = 2'd1,
    coh_e = 2'd2,
    coh_m = 2'd3
  } coh_state_e;

  typedef struct packed {
    logic [tag_width_c-1:0] tag;
    coh_state_e             state;
  } dir_entry_s;

  // every way of one LCE within one set
  typedef struct packed {
    dir_entry_s [lce_assoc_c-1:0] entry;
  } dir_row_s;

endpackage

`default_nettype wire

//--- coh_dir_ram.sv
/*
  coherence directory storage
  one entry write per cycle and a registered read of a whole
  LCE row, returned with its LCE index
*/
`timescale 1ns/1ns
`default_nettype none

module coh_dir_ram #(
  parameter int num_sets_p = coh_req_pkg::max_sets_c
) (
  input  logic                                clk_i,
  input  logic                                wr_v_i,
  input  coh_req_pkg::dir_wr_s                wr_i,
  input  logic                                rd_v_i,
  input  logic [coh_req_pkg::set_w_c-1:0]     rd_set_i,
  input  logic [coh_dir_pkg::lce_id_w_c-1:0]  rd_lce_i,
  output coh_dir_pkg::dir_row_s               rd_row_o,
  output logic                                rd_v_o,
  output logic [coh_dir_pkg::lce_id_w_c-1:0]  rd_lce_o
);
  import coh_dir_pkg::*;

  // rows indexed by set then LCE
  dir_row_s mem [num_sets_p][num_lce_c];

  // single entry write
  // sets beyond the configured count are dropped
  always_ff @(posedge clk_i) begin
    if (wr_v_i && (int'(wr_i.set) < num_sets_p)) begin
      mem[wr_i.set][wr_i.lce].entry[wr_i.way] <= wr_i.entry;
    end
  end

  // registered row read, index follows the data
  always_ff @(posedge clk_i) begin
    rd_v_o   <= rd_v_i;
    rd_lce_o <= rd_lce_i;
    if (rd_v_i) begin
      rd_row_o <= mem[rd_set_i][rd_lce_i];
    end
  end

endmodule

`default_nettype wire

//--- coh_dir_top.f
coh_dir_pkg.sv
coh_req_pkg.sv
coh_dir_ram.sv
coh_row_counter.sv
coh_sharers_collect.sv
coh_gad.sv
coh_lookup_fsm.sv
coh_dir_top.sv
tb_clk_gen.sv
coh_dir_chk.sv
tb_coh_dir.sv

//--- coh_dir_top.sv
/*
  coherence directory lookup unit
  directory RAM, row counter, sharers collector, GAD and the
  lookup sequencer wired together
*/
`timescale 1ns/1ns
`default_nettype none

module coh_dir_top #(
  parameter int num_sets_p = 16
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     lookup_v_i,
  input  coh_req_pkg::lookup_req_s lookup_i,
  input  logic                     dir_wr_v_i,
  input  coh_req_pkg::dir_wr_s     dir_wr_i,
  output logic                     busy_o,
  output logic                     result_v_o,
  output coh_req_pkg::gad_result_s result_o
);
  import coh_dir_pkg::*;
  import coh_req_pkg::*;

  // counter to RAM
  logic                  cnt_start;
  logic [lce_id_w_c-1:0] row_idx;
  logic                  row_v;
  logic                  cnt_last;
  // RAM to collector
  dir_row_s              row_data;
  logic                  row_data_v;
  logic [lce_id_w_c-1:0] row_data_lce;
  // collector to GAD and sequencer
  sharers_s              sharers;
  logic                  collect_done;
  gad_result_s           gad_result;
  lookup_req_s           req;
  logic                  wr_en;

  coh_lookup_fsm #(.num_sets_p(num_sets_p)) u_fsm (
    .clk_i(clk_i), .reset_i(reset_i), .lookup_v_i(lookup_v_i), .lookup_i(lookup_i),
    .dir_wr_v_i(dir_wr_v_i), .cnt_start_o(cnt_start), .cnt_last_i(cnt_last),
    .collect_done_i(collect_done), .gad_result_i(gad_result), .req_o(req),
    .wr_en_o(wr_en), .busy_o(busy_o), .result_v_o(result_v_o), .result_o(result_o)
  );

  coh_row_counter u_cnt (
    .clk_i(clk_i), .reset_i(reset_i), .start_i(cnt_start),
    .idx_o(row_idx), .v_o(row_v), .last_o(cnt_last)
  );

  coh_dir_ram #(.num_sets_p(num_sets_p)) u_ram (
    .clk_i(clk_i), .wr_v_i(wr_en), .wr_i(dir_wr_i),
    .rd_v_i(row_v), .rd_set_i(req.set), .rd_lce_i(row_idx),
    .rd_row_o(row_data), .rd_v_o(row_data_v), .rd_lce_o(row_data_lce)
  );

  coh_sharers_collect u_collect (
    .clk_i(clk_i), .reset_i(reset_i), .clear_i(cnt_start),
    .row_v_i(row_data_v), .row_i(row_data), .row_lce_i(row_data_lce),
    .tag_i(req.tag), .req_lce_i(req.lce), .lru_way_i(req.lru_way),
    .sharers_o(sharers), .done_o(collect_done)
  );

  coh_gad u_gad (
    .gad_v_i(collect_done), .sharers_i(sharers), .req_lce_i(req.lce),
    .req_type_i(req.req_type), .lru_dirty_i(req.lru_dirty), .result_o(gad_result)
  );

endmodule

`default_nettype wire

//--- coh_gad.sv
/*
  GAD block
  turns the collected sharers vectors into the requester way,
  the coherence flags and the transfer LCE and way
*/
`timescale 1ns/1ns
`default_nettype none

module coh_gad (
  input  logic                               gad_v_i,
  input  coh_req_pkg::sharers_s              sharers_i,
  input  logic [coh_dir_pkg::lce_id_w_c-1:0] req_lce_i,
  input  coh_req_pkg::req_type_e             req_type_i,
  input  logic                               lru_dirty_i,
  output coh_req_pkg::gad_result_s           result_o
);
  import coh_dir_pkg::*;
  import coh_req_pkg::*;

  logic [num_lce_c-1:0]  req_one_hot;
  logic [num_lce_c-1:0]  lce_excl;
  logic [num_lce_c-1:0]  other_hit;
  logic [num_lce_c-1:0]  other_excl;
  logic                  req_hit;
  logic                  req_excl;
  logic                  req_is_wr;
  logic                  cached;
  logic                  excl;
  logic                  upgrade;
  logic                  xfer_sel;
  logic [lce_id_w_c-1:0] xfer_lce;

  // requester as a one-hot mask
  assign req_one_hot = num_lce_c'(1) << req_lce_i;

  // hits held in E or M
  for (genvar i = 0; i < num_lce_c; i++) begin : g_excl
    assign lce_excl[i] = sharers_i.hits[i]
                         && ((sharers_i.states[i] == coh_e) || (sharers_i.states[i] == coh_m));
  end

  assign other_hit  = sharers_i.hits & ~req_one_hot;
  assign other_excl = lce_excl & ~req_one_hot;
  assign req_hit    = sharers_i.hits[req_lce_i];
  assign req_excl   = lce_excl[req_lce_i];
  assign req_is_wr  = (req_type_i == req_wr);

  assign cached  = |other_hit;
  assign excl    = |other_excl;
  // write to a line the requester holds in S
  assign upgrade = req_is_wr && req_hit && !req_excl;

  // lowest other LCE owning the line
  always_comb begin
    xfer_lce = '0;
    for (int i = num_lce_c - 1; i >= 0; i--) begin
      if (other_excl[i]) begin
        xfer_lce = lce_id_w_c'(i);
      end
    end
  end

  // transfer target only meaningful with complete sharers
  assign xfer_sel = gad_v_i && excl;

  always_comb begin
    result_o                  = '0;
    result_o.req_addr_way     = req_hit ? sharers_i.ways[req_lce_i] : '0;
    result_o.cached_flag      = cached;
    result_o.exclusive_flag   = excl;
    result_o.transfer_flag    = excl;
    result_o.upgrade_flag     = upgrade;
    result_o.replacement_flag = !upgrade && sharers_i.lru_cached_excl && lru_dirty_i;
    // reads only need an owner invalidated while writes need every sharer gone
    result_o.invalidate_flag  = req_is_wr ? cached : excl;
    result_o.transfer_lce     = xfer_sel ? xfer_lce : '0;
    result_o.transfer_way     = xfer_sel ? sharers_i.ways[xfer_lce] : '0;
  end

endmodule

`default_nettype wire

//--- coh_lookup_fsm.sv
/*
  lookup sequencer
  accepts a lookup while idle, walks the directory rows and
  registers the GAD result for one cycle
*/
`timescale 1ns/1ns
`default_nettype none

module coh_lookup_fsm #(
  parameter int num_sets_p = coh_req_pkg::max_sets_c
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     lookup_v_i,
  input  coh_req_pkg::lookup_req_s lookup_i,
  input  logic                     dir_wr_v_i,
  output logic                     cnt_start_o,
  input  logic                     cnt_last_i,
  input  logic                     collect_done_i,
  input  coh_req_pkg::gad_result_s gad_result_i,
  output coh_req_pkg::lookup_req_s req_o,
  output logic                     wr_en_o,
  output logic                     busy_o,
  output logic                     result_v_o,
  output coh_req_pkg::gad_result_s result_o
);
  import coh_req_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_result
  } state_e;

  state_e      state_r;
  logic        accept;
  logic        rows_done_r;
  lookup_req_s req_r;
  gad_result_s result_r;

  // out of range sets never start a lookup
  assign accept      = lookup_v_i && (state_r == st_idle) && (int'(lookup_i.set) < num_sets_p);
  assign cnt_start_o = accept;
  // directory only written between lookups
  assign wr_en_o     = dir_wr_v_i && (state_r == st_idle);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r     <= st_idle;
      rows_done_r <= 1'b0;
      result_r    <= '0;
    end else begin
      case (state_r)
        st_idle: begin
          rows_done_r <= 1'b0;
          if (accept) begin
            state_r <= st_read;
          end
        end
        st_read: begin
          // counter has issued its last row
          if (cnt_last_i) begin
            rows_done_r <= 1'b1;
          end
          if (collect_done_i && rows_done_r) begin
            result_r <= gad_result_i;
            state_r  <= st_result;
          end
        end
        default: begin
          state_r <= st_idle;
        end
      endcase
    end
  end

  // request held for the whole walk
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_r <= lookup_i;
    end
  end

  assign req_o      = req_r;
  assign busy_o     = (state_r != st_idle);
  assign result_v_o = (state_r == st_result);
  assign result_o   = result_r;

endmodule

`default_nettype wire

//--- coh_req_pkg.sv
/*
  lookup request package
  request type, lookup and directory write requests, the
  collected sharers vectors and the GAD result
*/
`default_nettype none

package coh_req_pkg;

  // largest set count a top level may ask for
  localparam int max_sets_c = 16;
  localparam int set_w_c    = $clog2(max_sets_c);

  typedef enum logic {
    req_rd = 1'b0,
    req_wr = 1'b1
  } req_type_e;

  typedef struct packed {
    logic [set_w_c-1:0]                  set;
    logic [coh_dir_pkg::tag_width_c-1:0] tag;
    logic [coh_dir_pkg::lce_id_w_c-1:0]  lce;
    req_type_e                           req_type;
    logic [coh_dir_pkg::way_w_c-1:0]     lru_way;
    logic                                lru_dirty;
  } lookup_req_s;

  typedef struct packed {
    logic [set_w_c-1:0]                 set;
    logic [coh_dir_pkg::lce_id_w_c-1:0] lce;
    logic [coh_dir_pkg::way_w_c-1:0]    way;
    coh_dir_pkg::dir_entry_s            entry;
  } dir_wr_s;

  // one slot per LCE
  typedef struct packed {
    logic [coh_dir_pkg::num_lce_c-1:0]                                hits;
    logic [coh_dir_pkg::num_lce_c-1:0][coh_dir_pkg::way_w_c-1:0]      ways;
    coh_dir_pkg::coh_state_e [coh_dir_pkg::num_lce_c-1:0]             states;
    logic                                                             lru_cached_excl;
  } sharers_s;

  typedef struct packed {
    logic [coh_dir_pkg::way_w_c-1:0]    req_addr_way;
    logic                               transfer_flag;
    logic [coh_dir_pkg::lce_id_w_c-1:0] transfer_lce;
    logic [coh_dir_pkg::way_w_c-1:0]    transfer_way;
    logic                               replacement_flag;
    logic                               upgrade_flag;
    logic                               invalidate_flag;
    logic                               exclusive_flag;
    logic                               cached_flag;
  } gad_result_s;

endpackage

`default_nettype wire

//--- coh_row_counter.sv
/*
  LCE row counter
  walks every LCE index once after a start strobe
*/
`timescale 1ns/1ns
`default_nettype none

module coh_row_counter (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               start_i,
  output logic [coh_dir_pkg::lce_id_w_c-1:0] idx_o,
  output logic                               v_o,
  output logic                               last_o
);
  import coh_dir_pkg::*;

  logic [lce_id_w_c-1:0] idx_r;
  logic                  v_r;
  logic                  at_last;

  assign at_last = (idx_r == lce_id_w_c'(num_lce_c - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      idx_r <= '0;
      v_r   <= 1'b0;
    end else if (start_i) begin
      idx_r <= '0;
      v_r   <= 1'b1;
    end else if (v_r) begin
      // stop after the final row
      if (at_last) begin
        v_r <= 1'b0;
      end else begin
        idx_r <= idx_r + 1'b1;
      end
    end
  end

  assign idx_o  = idx_r;
  assign v_o    = v_r;
  assign last_o = v_r && at_last;

endmodule

`default_nettype wire

//--- coh_sharers_collect.sv
/*
  sharers collector
  folds each returned directory row into the per LCE hit, way
  and state slots and picks up the LRU exclusive bit
*/
`timescale 1ns/1ns
`default_nettype none

module coh_sharers_collect (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                clear_i,
  input  logic                                row_v_i,
  input  coh_dir_pkg::dir_row_s               row_i,
  input  logic [coh_dir_pkg::lce_id_w_c-1:0]  row_lce_i,
  input  logic [coh_dir_pkg::tag_width_c-1:0] tag_i,
  input  logic [coh_dir_pkg::lce_id_w_c-1:0]  req_lce_i,
  input  logic [coh_dir_pkg::way_w_c-1:0]     lru_way_i,
  output coh_req_pkg::sharers_s               sharers_o,
  output logic                                done_o
);
  import coh_dir_pkg::*;
  import coh_req_pkg::*;

  logic               row_hit;
  logic [way_w_c-1:0] row_way;
  coh_state_e         row_state;
  coh_state_e         lru_state;
  sharers_s           sharers_r;
  logic               done_r;

  // tag match on a valid entry, lowest way wins
  always_comb begin
    row_hit   = 1'b0;
    row_way   = '0;
    row_state = coh_i;
    for (int w = lce_assoc_c - 1; w >= 0; w--) begin
      if ((row_i.entry[w].tag == tag_i) && (row_i.entry[w].state != coh_i)) begin
        row_hit   = 1'b1;
        row_way   = way_w_c'(w);
        row_state = row_i.entry[w].state;
      end
    end
  end

  // state of the requester's LRU way, tag not checked
  assign lru_state = row_i.entry[lru_way_i].state;

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      sharers_r <= '0;
      done_r    <= 1'b0;
    end else begin
      done_r <= 1'b0;
      if (row_v_i) begin
        sharers_r.hits[row_lce_i]   <= row_hit;
        sharers_r.ways[row_lce_i]   <= row_way;
        sharers_r.states[row_lce_i] <= row_state;
        if (row_lce_i == req_lce_i) begin
          sharers_r.lru_cached_excl <= (lru_state == coh_e) || (lru_state == coh_m);
        end
        // rows arrive in order, so the last index completes the set
        done_r <= (row_lce_i == lce_id_w_c'(num_lce_c - 1));
      end
    end
  end

  assign sharers_o = sharers_r;
  assign done_o    = done_r;

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# compile and run the coherence directory testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_coh_dir -f coh_dir_top.f -o tb_coh_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_coh_dir +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$log"; then
  exit 0
else
  exit 1
fi

//--- tb_clk_gen.sv
/*
  testbench clock generator
  free running clock with an 8 ns period
*/
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int half_period_p = 4
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(half_period_p) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- tb_coh_dir.sv
/*
  coherence directory lookup testbench
  random directory fill and random lookups from an LCG, checked
  against a directory model and the GAD flag rules
*/
`timescale 1ns/1ns
`default_nettype none

module tb_coh_dir;
  import coh_dir_pkg::*;
  import coh_req_pkg::*;

  localparam int num_sets_c  = 16;
  localparam int lookups_c   = 200;
  localparam int latency_c   = num_lce_c + 2;
  localparam int fill_c      = num_sets_c * num_lce_c * lce_assoc_c + 8 + 12;
  // a lookup takes its issue cycle, the latency and an idle check
  localparam int timeout_c   = fill_c + (lookups_c + 3) * (latency_c + 3) + 100;

  logic        clk;
  logic        reset;
  logic        lookup_v;
  lookup_req_s lookup;
  logic        dir_wr_v;
  dir_wr_s     dir_wr;
  logic        busy;
  logic        result_v;
  gad_result_s result;

  // mirror of the directory contents
  dir_entry_s  model [num_sets_c][num_lce_c][lce_assoc_c];
  logic [31:0] lcg_state = 32'd30;
  int          cycle_cnt = 0;

  tb_clk_gen u_clk (.clk_o(clk));

  coh_dir_top #(.num_sets_p(num_sets_c)) u_coh_dir_top (
    .clk_i(clk), .reset_i(reset), .lookup_v_i(lookup_v), .lookup_i(lookup),
    .dir_wr_v_i(dir_wr_v), .dir_wr_i(dir_wr), .busy_o(busy),
    .result_v_o(result_v), .result_o(result)
  );

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_result(input string name, input gad_result_s got,
                              input gad_result_s exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // upper half of the LCG word since its low bits cycle quickly
  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  // small tag pool so that hits are common
  function automatic logic [tag_width_c-1:0] pool_tag(input logic [1:0] sel);
    case (sel)
      2'd0:    return 8'h3c;
      2'd1:    return 8'ha5;
      2'd2:    return 8'h5a;
      default: return 8'hc3;
    endcase
  endfunction

  function automatic lookup_req_s random_req();
    lookup_req_s r;
    logic [15:0] a;
    logic [15:0] b;
    a = next_rand();
    b = next_rand();
    r.set       = a[3:0];
    r.tag       = pool_tag(a[5:4]);
    r.lce       = a[7:6];
    r.req_type  = req_type_e'(a[8]);
    r.lru_way   = a[9];
    r.lru_dirty = b[0];
    return r;
  endfunction

  function automatic dir_wr_s make_wr(input int s, input int l, input int w,
                                      input logic [tag_width_c-1:0] tag, input coh_state_e st);
    dir_wr_s d;
    d.set         = set_w_c'(s);
    d.lce         = lce_id_w_c'(l);
    d.way         = way_w_c'(w);
    d.entry.tag   = tag;
    d.entry.state = st;
    return d;
  endfunction

  // reference flags from the hit and flag rules
  function automatic gad_result_s expected_result(input lookup_req_s r);
    gad_result_s          e;
    logic [num_lce_c-1:0] hit;
    logic [way_w_c-1:0]   hway [num_lce_c];
    coh_state_e           hstate [num_lce_c];
    dir_entry_s           ent;
    logic                 owner;
    e   = '0;
    hit = '0;
    for (int l = 0; l < num_lce_c; l++) begin
      hway[l]   = '0;
      hstate[l] = coh_i;
      for (int w = 0; w < lce_assoc_c; w++) begin
        ent = model[r.set][l][w];
        if (!hit[l] && (ent.tag == r.tag) && (ent.state != coh_i)) begin
          hit[l]    = 1'b1;
          hway[l]   = way_w_c'(w);
          hstate[l] = ent.state;
        end
      end
    end
    for (int l = 0; l < num_lce_c; l++) begin
      owner = hit[l] && ((hstate[l] == coh_e) || (hstate[l] == coh_m));
      if ((l != int'(r.lce)) && hit[l]) begin
        e.cached_flag = 1'b1;
        // first owner found is the lowest one
        if (owner && !e.exclusive_flag) begin
          e.transfer_lce   = lce_id_w_c'(l);
          e.transfer_way   = hway[l];
          e.exclusive_flag = 1'b1;
        end
      end
    end
    e.transfer_flag    = e.exclusive_flag;
    e.upgrade_flag     = (r.req_type == req_wr) && hit[r.lce] && (hstate[r.lce] == coh_s);
    ent                = model[r.set][r.lce][r.lru_way];
    e.replacement_flag = !e.upgrade_flag && r.lru_dirty
                         && ((ent.state == coh_e) || (ent.state == coh_m));
    e.invalidate_flag  = (r.req_type == req_wr) ? e.cached_flag : e.exclusive_flag;
    e.req_addr_way     = hit[r.lce] ? hway[r.lce] : '0;
    return e;
  endfunction

  task automatic write_entry(input dir_wr_s w);
    @(negedge clk);
    dir_wr_v = 1'b1;
    dir_wr   = w;
    model[w.set][w.lce][w.way] = w.entry;
  endtask

  // one lookup with an optional stray write and strobe while busy
  task automatic run_lookup(input lookup_req_s r, input logic stray);
    gad_result_s exp;
    @(negedge clk);
    dir_wr_v = 1'b0;
    lookup_v = 1'b1;
    lookup   = r;
    exp      = expected_result(r);
    for (int n = 1; n <= latency_c + 1; n++) begin
      @(negedge clk);
      lookup_v = 1'b0;
      dir_wr_v = 1'b0;
      if ((n == 1) && stray) begin
        lookup_v = 1'b1;
        lookup   = random_req();
        dir_wr_v = 1'b1;
        dir_wr   = make_wr(0, 0, 0, 8'hff, coh_m);
        dir_wr.set = r.set;
      end
      check_bit("busy_o", busy, 1'b1);
      check_bit("result_v_o", result_v, n == latency_c + 1);
    end
    check_result("result_o", result, exp);
    @(negedge clk);
    check_bit("busy_o", busy, 1'b0);
    check_bit("result_v_o", result_v, 1'b0);
    check_result("result_o", result, exp);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_c) begin
      stop_with_failure("timeout, the test sequence did not finish in time");
    end else if (u_coh_dir_top.u_chk.fail_cnt != 0) begin
      stop_with_failure("a bound assertion on the lookup unit failed");
    end
  end

  initial begin
    lookup_req_s r;
    logic [15:0] a;
    reset    = 1'b1;
    lookup_v = 1'b0;
    lookup   = '0;
    dir_wr_v = 1'b0;
    dir_wr   = '0;
    repeat (8) @(negedge clk);
    check_bit("busy_o", busy, 1'b0);
    check_bit("result_v_o", result_v, 1'b0);
    check_result("result_o", result, '0);
    reset = 1'b0;

    // random fill of the whole directory
    for (int s = 0; s < num_sets_c; s++) begin
      for (int l = 0; l < num_lce_c; l++) begin
        for (int w = 0; w < lce_assoc_c; w++) begin
          a = next_rand();
          write_entry(make_wr(s, l, w, pool_tag(a[1:0]), coh_state_e'(a[3:2])));
        end
      end
    end

    // set 0 with two owners of each tag and requester cases for upgrade and replacement
    write_entry(make_wr(0, 0, 0, 8'h3c, coh_s));
    write_entry(make_wr(0, 0, 1, 8'ha5, coh_m));
    write_entry(make_wr(0, 1, 0, 8'ha5, coh_s));
    write_entry(make_wr(0, 1, 1, 8'h3c, coh_e));
    write_entry(make_wr(0, 2, 0, 8'h3c, coh_m));
    write_entry(make_wr(0, 2, 1, 8'ha5, coh_i));
    write_entry(make_wr(0, 3, 0, 8'ha5, coh_e));
    write_entry(make_wr(0, 3, 1, 8'ha5, coh_s));
    run_lookup('{set: 4'd0, tag: 8'h3c, lce: 2'd0, req_type: req_wr,
                 lru_way: 1'b1, lru_dirty: 1'b1}, 1'b0);
    run_lookup('{set: 4'd0, tag: 8'ha5, lce: 2'd3, req_type: req_rd,
                 lru_way: 1'b0, lru_dirty: 1'b1}, 1'b0);
    run_lookup('{set: 4'd0, tag: 8'h3c, lce: 2'd3, req_type: req_wr,
                 lru_way: 1'b1, lru_dirty: 1'b0}, 1'b1);

    for (int i = 0; i < lookups_c; i++) begin
      r = random_req();
      a = next_rand();
      run_lookup(r, a[1:0] == 2'd0);
    end

    if (u_coh_dir_top.u_chk.fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      stop_with_failure("bound assertion checks reported failures");
    end
  end

endmodule

`default_nettype wire
